// File: logic/shmem_pkg.sv
package shmem_pkg;

// Memory operation carried with every core request
typedef enum logic
{
	OP_READ  = 1'b0,
	OP_WRITE = 1'b1
} mem_op_e;

// Snapshot sequencer
typedef enum logic [1:0]
{
	SNAP_IDLE = 2'd0,
	SNAP_COPY = 2'd1,	// Stepping the offset over every bank word
	SNAP_LAST = 2'd2	// Final word lands in the shadows
} snap_state_e;

// Default sizes for the top level
localparam int DEF_NUM_CORES  = 4;
localparam int DEF_NUM_BANKS  = 4;
localparam int DEF_BANK_DEPTH = 64;
localparam int DEF_DATA_W     = 16;

endpackage

// File: logic/core_req_if.sv
`timescale 1ns/10ps

interface core_req_if import shmem_pkg::*;
#(
	parameter int NUM_BANKS = DEF_NUM_BANKS,
	parameter int BANK_DEPTH = DEF_BANK_DEPTH,
	parameter int DATA_W = DEF_DATA_W
)
();

	logic				valid;
	mem_op_e			op;
	logic	[$clog2(NUM_BANKS)-1:0]	bank;
	logic	[$clog2(BANK_DEPTH)-1:0]	offset;
	logic	[DATA_W-1:0]		wr_data;
	logic				ready;		// Grant from the bank arbiter
	logic				rd_valid;
	logic	[DATA_W-1:0]		rd_data;

	modport stage (output valid, op, bank, offset, wr_data, input ready);

	modport crossbar (input valid, op, bank, offset, wr_data, output ready, rd_valid, rd_data);

endinterface

// File: logic/request_stage.sv
`timescale 1ns/10ps

module request_stage import shmem_pkg::*;
#(
	parameter int NUM_BANKS = DEF_NUM_BANKS,
	parameter int BANK_DEPTH = DEF_BANK_DEPTH,
	parameter int DATA_W = DEF_DATA_W,
	localparam int BANK_W = $clog2(NUM_BANKS),
	localparam int OFF_W = $clog2(BANK_DEPTH),
	localparam int ADDR_W = BANK_W + OFF_W
)
(
	input	logic			clk,
	input	logic			reset,
	input	logic			in_valid,
	output	logic			in_ready,
	input	mem_op_e		in_op,
	input	logic	[ADDR_W-1:0]	in_addr,
	input	logic	[DATA_W-1:0]	in_wr_data,
	core_req_if.stage		req
);

// Empty, or the held request leaves in this cycle
assign in_ready = !req.valid || req.ready;

always_ff @(posedge clk)
begin
	if (reset)
		req.valid <= 1'b0;
	else if (in_ready)
		req.valid <= in_valid;
end

always_ff @(posedge clk)
begin
	if (in_ready && in_valid)
	begin
		req.op <= in_op;
		{req.bank, req.offset} <= in_addr;	// Bank index sits above the offset
		req.wr_data <= in_wr_data;
	end
end

endmodule

// File: logic/rr_pick.sv
`timescale 1ns/10ps

module rr_pick
#(
	parameter int NUM_CORES = 4,
	localparam int CORE_W = $clog2(NUM_CORES)
)
(
	input	logic	[NUM_CORES-1:0]	mask,
	input	logic	[CORE_W-1:0]	start,
	output	logic			found,
	output	logic	[CORE_W-1:0]	winner
);

always_comb
begin
	int unsigned idx;

	found = 1'b0;
	winner = start;
	// Start is checked last so the last served core has lowest priority
	for (int i = 1; i <= NUM_CORES; i++)
	begin
		idx = (int'(start) + i) % NUM_CORES;
		if (!found && mask[idx])
		begin
			found = 1'b1;
			winner = CORE_W'(idx);
		end
	end
end

endmodule

// File: logic/mem_bank.sv
`timescale 1ns/10ps

module mem_bank
#(
	parameter int DEPTH = 64,
	parameter int DATA_W = 16,
	localparam int ADDR_W = $clog2(DEPTH)
)
(
	input	logic			clk,
	input	logic	[ADDR_W-1:0]	addr,
	input	logic	[DATA_W-1:0]	wr_data,
	input	logic			write,
	output	logic	[DATA_W-1:0]	rd_data
);

logic	[DATA_W-1:0]	mem	[DEPTH];

always_ff @(posedge clk)
begin
	if (write)
		mem[addr] <= wr_data;
	rd_data <= mem[addr];	// Not meaningful in a write cycle
end

endmodule

// File: logic/bank_crossbar.sv
`timescale 1ns/10ps

module bank_crossbar import shmem_pkg::*;
#(
	parameter int NUM_CORES = DEF_NUM_CORES,
	parameter int NUM_BANKS = DEF_NUM_BANKS,
	parameter int BANK_DEPTH = DEF_BANK_DEPTH,
	parameter int DATA_W = DEF_DATA_W,
	localparam int CORE_W = $clog2(NUM_CORES),
	localparam int BANK_W = $clog2(NUM_BANKS),
	localparam int OFF_W = $clog2(BANK_DEPTH)
)
(
	input	logic					clk,
	input	logic					reset,
	core_req_if.crossbar				core [NUM_CORES],
	input	logic					snap_active,
	input	logic	[OFF_W-1:0]			snap_offset,
	output	logic	[NUM_BANKS-1:0][DATA_W-1:0]	bank_rd_data
);

logic	[NUM_CORES-1:0]		req_valid;
mem_op_e			req_op		[NUM_CORES];
logic	[BANK_W-1:0]		req_bank	[NUM_CORES];
logic	[OFF_W-1:0]		req_offset	[NUM_CORES];
logic	[DATA_W-1:0]		req_wr_data	[NUM_CORES];
logic	[NUM_CORES-1:0]		grant;
logic	[NUM_CORES-1:0]		rd_pend;	// Read granted last cycle
logic	[BANK_W-1:0]		rd_bank		[NUM_CORES];

logic	[NUM_CORES-1:0]		bank_mask	[NUM_BANKS];
logic	[NUM_BANKS-1:0]		bank_found;
logic	[CORE_W-1:0]		bank_winner	[NUM_BANKS];
logic	[CORE_W-1:0]		rr_ptr		[NUM_BANKS];
logic	[OFF_W-1:0]		bank_addr	[NUM_BANKS];
logic	[DATA_W-1:0]		bank_wr_data	[NUM_BANKS];
logic	[NUM_BANKS-1:0]		bank_write;

genvar c, b;

generate
for (c = 0; c < NUM_CORES; c++)
begin : g_core
	assign req_valid[c] = core[c].valid;
	assign req_op[c] = core[c].op;
	assign req_bank[c] = core[c].bank;
	assign req_offset[c] = core[c].offset;
	assign req_wr_data[c] = core[c].wr_data;

	// Core wins the bank it is aiming at
	assign grant[c] = !snap_active && bank_found[req_bank[c]]
		&& (bank_winner[req_bank[c]] == CORE_W'(c));

	assign core[c].ready = grant[c];
	assign core[c].rd_valid = rd_pend[c];
	assign core[c].rd_data = bank_rd_data[rd_bank[c]];
end

for (b = 0; b < NUM_BANKS; b++)
begin : g_bank
	for (c = 0; c < NUM_CORES; c++)
	begin : g_mask
		assign bank_mask[b][c] = req_valid[c] && (req_bank[c] == BANK_W'(b));
	end

	rr_pick #(.NUM_CORES(NUM_CORES)) u_pick
	(
		.mask(bank_mask[b]),
		.start(rr_ptr[b]),
		.found(bank_found[b]),
		.winner(bank_winner[b])
	);

	// Snapshot takes the whole bank over
	assign bank_addr[b] = snap_active ? snap_offset : req_offset[bank_winner[b]];
	assign bank_wr_data[b] = req_wr_data[bank_winner[b]];
	assign bank_write[b] = !snap_active && bank_found[b]
		&& (req_op[bank_winner[b]] == OP_WRITE);

	mem_bank #(.DEPTH(BANK_DEPTH), .DATA_W(DATA_W)) u_bank
	(
		.clk(clk),
		.addr(bank_addr[b]),
		.wr_data(bank_wr_data[b]),
		.write(bank_write[b]),
		.rd_data(bank_rd_data[b])
	);
end
endgenerate

always_ff @(posedge clk)
begin
	for (int i = 0; i < NUM_BANKS; i++)
	begin
		if (reset)
			rr_ptr[i] <= '0;
		else if (bank_found[i] && !snap_active)
			rr_ptr[i] <= bank_winner[i];
	end
end

always_ff @(posedge clk)
begin
	for (int i = 0; i < NUM_CORES; i++)
	begin
		if (reset)
			rd_pend[i] <= 1'b0;
		else
			rd_pend[i] <= grant[i] && (req_op[i] == OP_READ);
	end
end

// Remember which bank answers each core
always_ff @(posedge clk)
begin
	for (int i = 0; i < NUM_CORES; i++)
		rd_bank[i] <= req_bank[i];
end

endmodule

// File: logic/snapshot_copy.sv
`timescale 1ns/10ps

module snapshot_copy import shmem_pkg::*;
#(
	parameter int NUM_BANKS = DEF_NUM_BANKS,
	parameter int BANK_DEPTH = DEF_BANK_DEPTH,
	parameter int DATA_W = DEF_DATA_W,
	localparam int BANK_W = $clog2(NUM_BANKS),
	localparam int OFF_W = $clog2(BANK_DEPTH),
	localparam int ADDR_W = BANK_W + OFF_W
)
(
	input	logic					clk,
	input	logic					reset,
	input	logic					dump_start,
	output	logic					dump_busy,
	output	logic					dump_done,
	output	logic					snap_active,
	output	logic	[OFF_W-1:0]			snap_offset,
	input	logic	[NUM_BANKS-1:0][DATA_W-1:0]	bank_rd_data,
	input	logic	[ADDR_W-1:0]			view_addr,
	output	logic	[DATA_W-1:0]			view_data
);

snap_state_e			state;
logic	[OFF_W-1:0]		copy_offset;
logic				shadow_write;
logic	[OFF_W-1:0]		shadow_wr_offset;
logic	[OFF_W-1:0]		shadow_addr;
logic	[BANK_W-1:0]		view_bank;
logic	[OFF_W-1:0]		view_offset;
logic	[BANK_W-1:0]		view_bank_q;
logic	[NUM_BANKS-1:0][DATA_W-1:0]	shadow_rd_data;

assign {view_bank, view_offset} = view_addr;

always_ff @(posedge clk)
begin
	if (reset)
	begin
		state <= SNAP_IDLE;
		copy_offset <= '0;
	end
	else
	begin
		case (state)
			SNAP_IDLE:
				if (dump_start)
				begin
					state <= SNAP_COPY;
					copy_offset <= '0;
				end
			SNAP_COPY:
				if (copy_offset == OFF_W'(BANK_DEPTH - 1))
					state <= SNAP_LAST;
				else
					copy_offset <= copy_offset + 1'b1;
			default:
				state <= SNAP_IDLE;
		endcase
	end
end

// Bank data arrives one cycle after its read
always_ff @(posedge clk)
begin
	if (reset)
		shadow_write <= 1'b0;
	else
		shadow_write <= (state == SNAP_COPY);
end

always_ff @(posedge clk)
begin
	shadow_wr_offset <= copy_offset;
	view_bank_q <= view_bank;	// Lines up with the shadow read
end

assign snap_active = (state != SNAP_IDLE);
assign snap_offset = copy_offset;
assign dump_busy = snap_active;
assign dump_done = (state == SNAP_LAST);
assign shadow_addr = shadow_write ? shadow_wr_offset : view_offset;
assign view_data = shadow_rd_data[view_bank_q];

genvar b;

generate
for (b = 0; b < NUM_BANKS; b++)
begin : g_shadow
	mem_bank #(.DEPTH(BANK_DEPTH), .DATA_W(DATA_W)) u_shadow
	(
		.clk(clk),
		.addr(shadow_addr),
		.wr_data(bank_rd_data[b]),
		.write(shadow_write),
		.rd_data(shadow_rd_data[b])
	);
end
endgenerate

endmodule

// File: logic/shared_mem_top.sv
`timescale 1ns/10ps

module shared_mem_top import shmem_pkg::*;
#(
	parameter int NUM_CORES = DEF_NUM_CORES,
	parameter int NUM_BANKS = DEF_NUM_BANKS,
	parameter int BANK_DEPTH = DEF_BANK_DEPTH,
	parameter int DATA_W = DEF_DATA_W,
	localparam int OFF_W = $clog2(BANK_DEPTH),
	localparam int ADDR_W = $clog2(NUM_BANKS) + OFF_W
)
(
	input	logic					clk,
	input	logic					reset,
	input	logic	[NUM_CORES-1:0]			in_valid,
	output	logic	[NUM_CORES-1:0]			in_ready,
	input	mem_op_e	[NUM_CORES-1:0]		in_op,
	input	logic	[NUM_CORES-1:0][ADDR_W-1:0]	in_addr,
	input	logic	[NUM_CORES-1:0][DATA_W-1:0]	in_wr_data,
	output	logic	[NUM_CORES-1:0]			rd_valid,
	output	logic	[NUM_CORES-1:0][DATA_W-1:0]	rd_data,
	input	logic					dump_start,
	output	logic					dump_busy,
	output	logic					dump_done,
	input	logic	[ADDR_W-1:0]			view_addr,
	output	logic	[DATA_W-1:0]			view_data
);

logic				snap_active;
logic	[OFF_W-1:0]		snap_offset;
logic	[NUM_BANKS-1:0][DATA_W-1:0]	bank_rd_data;

core_req_if #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH), .DATA_W(DATA_W)) req [NUM_CORES] ();

genvar c;

generate
for (c = 0; c < NUM_CORES; c++)
begin : g_core
	request_stage #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH), .DATA_W(DATA_W)) u_stage
	(
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid[c]),
		.in_ready(in_ready[c]),
		.in_op(in_op[c]),
		.in_addr(in_addr[c]),
		.in_wr_data(in_wr_data[c]),
		.req(req[c])
	);

	assign rd_valid[c] = req[c].rd_valid;
	assign rd_data[c] = req[c].rd_data;
end
endgenerate

bank_crossbar #(
	.NUM_CORES(NUM_CORES),
	.NUM_BANKS(NUM_BANKS),
	.BANK_DEPTH(BANK_DEPTH),
	.DATA_W(DATA_W)
) u_crossbar
(
	.clk(clk),
	.reset(reset),
	.core(req),
	.snap_active(snap_active),
	.snap_offset(snap_offset),
	.bank_rd_data(bank_rd_data)
);

snapshot_copy #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH), .DATA_W(DATA_W)) u_snapshot
(
	.clk(clk),
	.reset(reset),
	.dump_start(dump_start),
	.dump_busy(dump_busy),
	.dump_done(dump_done),
	.snap_active(snap_active),
	.snap_offset(snap_offset),
	.bank_rd_data(bank_rd_data),
	.view_addr(view_addr),
	.view_data(view_data)
);

endmodule

// File: sim/shared_mem_tb.sv
`timescale 1ns/10ps

module shared_mem_tb import shmem_pkg::*;
();

localparam int NUM_CORES = DEF_NUM_CORES;
localparam int NUM_BANKS = DEF_NUM_BANKS;
localparam int BANK_DEPTH = DEF_BANK_DEPTH;
localparam int DATA_W = DEF_DATA_W;
localparam int ADDR_W = $clog2(NUM_BANKS) + $clog2(BANK_DEPTH);
localparam int WORDS = NUM_BANKS * BANK_DEPTH;
localparam int STRIPE = BANK_DEPTH / NUM_CORES;	// Offsets owned by one core in one bank
localparam int CLK_PERIOD = 20;
localparam int SINGLE_OPS = 60;
localparam int SAME_OPS = 24;
localparam int MULTI_OPS = 48;
localparam int DUMP_OPS = 40;
localparam int TEST_CYCLES = WORDS / NUM_CORES + SINGLE_OPS + SAME_OPS + MULTI_OPS
	+ DUMP_OPS + STRIPE + BANK_DEPTH + 2 * WORDS;
localparam int WATCHDOG_NS = (TEST_CYCLES * NUM_CORES + 2000) * CLK_PERIOD;

logic					clk;
logic					reset;
logic	[NUM_CORES-1:0]			in_valid;
logic	[NUM_CORES-1:0]			in_ready;
mem_op_e	[NUM_CORES-1:0]		in_op;
logic	[NUM_CORES-1:0][ADDR_W-1:0]	in_addr;
logic	[NUM_CORES-1:0][DATA_W-1:0]	in_wr_data;
logic	[NUM_CORES-1:0]			rd_valid;
logic	[NUM_CORES-1:0][DATA_W-1:0]	rd_data;
logic					dump_start;
logic					dump_busy;
logic					dump_done;
logic	[ADDR_W-1:0]			view_addr;
logic	[DATA_W-1:0]			view_data;

logic	[31:0]		seed = 32'd78109;
int			error_count = 0;
int			test_count = 0;
logic	[DATA_W-1:0]	ref_mem		[WORDS];	// Updated at top transfers
logic	[DATA_W-1:0]	bank_mem	[WORDS];	// Updated at grants
logic	[DATA_W-1:0]	snap_mem	[WORDS];
logic	[DATA_W-1:0]	exp_q		[NUM_CORES][$];
logic	[NUM_CORES-1:0]	held;		// Mirror of each request stage
mem_op_e		held_op		[NUM_CORES];
logic	[ADDR_W-1:0]	held_addr	[NUM_CORES];
logic	[DATA_W-1:0]	held_data	[NUM_CORES];
logic	[NUM_CORES-1:0]	resp_seen;
logic	[NUM_CORES-1:0]	resp_ok;
logic	[DATA_W-1:0]	resp_data	[NUM_CORES];
logic	[DATA_W-1:0]	resp_expect	[NUM_CORES];
int			stall_cnt	[NUM_CORES];
int			busy_cnt;
logic			view_on;
logic			view_check;
logic	[DATA_W-1:0]	view_expect;

shared_mem_top UUT (.*);

initial
begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial
begin
	#(WATCHDOG_NS);
	$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
	$display(">>> FAIL");
	$finish;
end

function automatic logic [31:0] next_rand();
	seed = seed * 32'd1103515245 + 32'd12345;
	return seed;
endfunction

// Odd multiplier so every address bit changes the word
function automatic logic [DATA_W-1:0] fill_value(input logic [ADDR_W-1:0] addr);
	return DATA_W'(addr * 16'h9e37 + 16'h1b5d);
endfunction

task automatic log_check_failure(input string msg);
	error_count++;
	$display("CHECK FAILED at %0d ns: %s", $time, msg);
endtask

task automatic finish_test(input string name);
	test_count++;
	$display("Test %0d (%s) finished, %0d failed checks so far", test_count, name, error_count);
endtask

task automatic issue_request(input int c, input mem_op_e op, input int addr,
	input logic [DATA_W-1:0] data);
	in_valid[c] <= 1'b1;
	in_op[c] <= op;
	in_addr[c] <= ADDR_W'(addr);
	in_wr_data[c] <= data;
	do
		@(posedge clk);
	while (!in_ready[c]);
	in_valid[c] <= 1'b0;	// Overridden when the next request follows at once
endtask

task automatic random_traffic(input int c, input int n, input int bank_sel);
	logic	[31:0]	r;
	int		bank;
	int		offset;
	for (int i = 0; i < n; i++)
	begin
		r = next_rand();
		bank = (bank_sel < 0) ? int'(r[29:24]) % NUM_BANKS : bank_sel;
		offset = (int'(r[23:16]) % STRIPE) * NUM_CORES + c;
		issue_request(c, r[31] ? OP_WRITE : OP_READ, bank * BANK_DEPTH + offset,
			DATA_W'(next_rand() >> 8));
	end
endtask

task automatic fill_stripe(input int c);
	int	addr;
	for (int b = 0; b < NUM_BANKS; b++)
		for (int k = 0; k < STRIPE; k++)
		begin
			addr = ((b + c) % NUM_BANKS) * BANK_DEPTH + k * NUM_CORES + c;
			issue_request(c, OP_WRITE, addr, fill_value(ADDR_W'(addr)));
		end
endtask

task automatic all_cores_traffic(input int n, input int bank_sel);
	for (int c = 0; c < NUM_CORES; c++)
	begin
		fork
			automatic int core = c;
			if (n == 0)
				fill_stripe(core);
			else
				random_traffic(core, n, bank_sel);
		join_none
	end
	wait fork;
endtask

// Stages empty and two more cycles for the last read data
task automatic wait_drained();
	do
		@(posedge clk);
	while (held != '0 || in_valid != '0);
	repeat (2) @(posedge clk);
	for (int c = 0; c < NUM_CORES; c++)
		assert (exp_q[c].size() == 0)
		else log_check_failure($sformatf("core %0d still waits for %0d reads",
			c, exp_q[c].size()));
endtask

task automatic run_dump();
	repeat (6) @(posedge clk);
	dump_start <= 1'b1;
	@(posedge clk);
	dump_start <= 1'b0;
	do
		@(posedge clk);
	while (!dump_busy);
	do
		@(posedge clk);
	while (dump_busy);
endtask

task automatic sweep_view();
	for (int a = 0; a < WORDS; a++)
	begin
		view_addr <= ADDR_W'(a);
		view_on <= 1'b1;
		@(posedge clk);
	end
	view_on <= 1'b0;
	repeat (2) @(posedge clk);
endtask

always @(posedge clk)
begin
	if (reset)
	begin
		held <= '0;
		resp_seen <= '0;
		busy_cnt <= 0;
		view_check <= 1'b0;
		for (int c = 0; c < NUM_CORES; c++)
			stall_cnt[c] <= 0;
	end
	else
	begin
		for (int c = 0; c < NUM_CORES; c++)
		begin
			resp_seen[c] <= rd_valid[c];
			resp_data[c] <= rd_data[c];
			resp_ok[c] <= (exp_q[c].size() != 0);
			if (rd_valid[c] && exp_q[c].size() != 0)
				resp_expect[c] <= exp_q[c].pop_front();
			if (held[c] && in_ready[c])
			begin
				held[c] <= 1'b0;
				if (held_op[c] == OP_WRITE)
					bank_mem[held_addr[c]] = held_data[c];
			end
			if (in_valid[c] && in_ready[c])
			begin
				held[c] <= 1'b1;
				held_op[c] <= in_op[c];
				held_addr[c] <= in_addr[c];
				held_data[c] <= in_wr_data[c];
				if (in_op[c] == OP_WRITE)
					ref_mem[in_addr[c]] = in_wr_data[c];
				else
					exp_q[c].push_back(ref_mem[in_addr[c]]);
			end
			if (in_valid[c] && !in_ready[c] && !dump_busy)
				stall_cnt[c] <= stall_cnt[c] + 1;
			else
				stall_cnt[c] <= 0;
		end
		if (dump_start && !dump_busy)
			snap_mem = bank_mem;	// Grants of this edge are already in
		busy_cnt <= dump_busy ? busy_cnt + 1 : 0;
		view_expect <= snap_mem[view_addr];
		view_check <= view_on;
	end
end

assert property (@(posedge clk) $fell(reset)
	|-> (&in_ready) && rd_valid == '0 && !dump_busy && !dump_done)
else log_check_failure("outputs are not idle after reset");

assert property (@(posedge clk) disable iff (reset)
	dump_done == (dump_busy && busy_cnt == BANK_DEPTH))
else log_check_failure($sformatf("dump_done is %b after %0d busy cycles, sequencer now %s",
	$sampled(dump_done), $sampled(busy_cnt), UUT.u_snapshot.state.name()));

assert property (@(posedge clk) disable iff (reset)
	$fell(dump_busy) |-> busy_cnt == BANK_DEPTH + 1)
else log_check_failure($sformatf("dump_busy lasted %0d cycles", $sampled(busy_cnt)));

assert property (@(posedge clk) disable iff (reset) dump_busy && busy_cnt >= 2 |-> rd_valid == '0)
else log_check_failure("read data returned while the dump holds the banks");

assert property (@(posedge clk) disable iff (reset) view_check |-> view_data === view_expect)
else log_check_failure($sformatf("view_data %h, expected %h",
	$sampled(view_data), $sampled(view_expect)));

for (genvar g = 0; g < NUM_CORES; g++)
begin : g_core_check
	assert property (@(posedge clk) disable iff (reset)
		resp_seen[g] |-> resp_ok[g] && resp_data[g] === resp_expect[g])
	else log_check_failure($sformatf("core %0d read data %h, expected %h", g,
		$sampled(resp_data[g]), $sampled(resp_expect[g])));

	assert property (@(posedge clk) disable iff (reset) stall_cnt[g] <= NUM_CORES + 1)
	else log_check_failure($sformatf("core %0d held off for %0d cycles", g,
		$sampled(stall_cnt[g])));
end

initial
begin
	reset = 1'b1;
	in_valid = '0;
	in_addr = '0;
	in_wr_data = '0;
	dump_start = 1'b0;
	view_addr = '0;
	view_on = 1'b0;
	for (int c = 0; c < NUM_CORES; c++)
		in_op[c] = OP_READ;
	repeat (3) @(posedge clk);
	reset <= 1'b0;
	repeat (2) @(posedge clk);
	finish_test("reset state");

	all_cores_traffic(0, -1);	// Known contents everywhere
	wait_drained();

	random_traffic(0, SINGLE_OPS, -1);
	wait_drained();
	finish_test("single core random");

	all_cores_traffic(SAME_OPS, 1);
	wait_drained();
	finish_test("same bank contention");

	all_cores_traffic(MULTI_OPS, -1);
	wait_drained();
	finish_test("multi core random");

	fork
		all_cores_traffic(DUMP_OPS, -1);
		run_dump();
	join
	wait_drained();
	finish_test("snapshot under traffic");

	sweep_view();
	for (int i = 0; i < STRIPE; i++)
		issue_request(0, OP_WRITE, i * NUM_CORES, ~fill_value(ADDR_W'(i * NUM_CORES)));
	wait_drained();
	sweep_view();	// Shadow copy keeps the old words
	finish_test("display view");

	$display("Tests run: %0d, failed checks: %0d", test_count, error_count);
	if (error_count == 0)
		$display(">>> PASS");
	else
		$display(">>> FAIL");
	$finish;
end

endmodule

// File: shared_mem.f
logic/shmem_pkg.sv
logic/core_req_if.sv
logic/request_stage.sv
logic/rr_pick.sv
logic/mem_bank.sv
logic/bank_crossbar.sv
logic/snapshot_copy.sv
logic/shared_mem_top.sv
sim/shared_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= shared_mem_tb
FILELIST ?= shared_mem.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= >>> PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx -- '$(PASS_TEXT)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
